// ==== rtl/tlb_pkg.sv ====
package tlb_pkg;

    // Table geometry
    localparam int TLB_NUM = 16;
    localparam int IDX_W   = 4;

    // Field widths
    localparam int ASID_W = 10;
    localparam int VPPN_W = 19;
    localparam int PPN_W  = 20;

    // Page size codes, anything other than 4 KB is a 2 MB page
    localparam int PS_4K = 12;
    localparam int PS_2M = 21;

    localparam logic [1:0] MAT_CC = 2'd1;

    typedef logic [31:0]       va_t;
    typedef logic [31:0]       pa_t;
    typedef logic [VPPN_W-1:0] vppn_t;
    typedef logic [PPN_W-1:0]  ppn_t;
    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [IDX_W-1:0]  tlb_idx_t;
    typedef logic [5:0]        ps_t;
    typedef logic [1:0]        mat_t;

    // Window register: vseg 31..29, pseg 27..25, mat 5..4
    typedef logic [31:0]       dmw_t;

    typedef enum logic [2:0] {
        MOP_WRITE,
        MOP_SEARCH,
        MOP_INV_ALL,
        MOP_INV_ASID,
        MOP_INV_VA
    } maint_op_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WRITE,
        MS_SWEEP,
        MS_ACK
    } maint_state_t;

    // Translation match of one entry against a VA
    function automatic logic entry_hits_va(input logic e, input logic g, input asid_t asid,
                                           input ps_t ps, input vppn_t vppn,
                                           input asid_t cur_asid, input va_t va);
        logic asid_ok;
        logic page_ok;
        asid_ok = g || (asid == cur_asid);
        if (ps == ps_t'(PS_4K))
            page_ok = (vppn == va[31:PS_4K+1]);
        else
            page_ok = (vppn[VPPN_W-1:PS_2M-12] == va[31:PS_2M+1]);
        return e && asid_ok && page_ok;
    endfunction

endpackage

// ==== rtl/tlb_entry_array.sv ====
`timescale 1ns/1ns

module tlb_entry_array (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wr_en,
    input  tlb_pkg::tlb_idx_t             wr_index,
    input  tlb_pkg::asid_t                wr_asid,
    input  logic                          wr_g,
    input  tlb_pkg::ps_t                  wr_ps,
    input  tlb_pkg::vppn_t                wr_vppn,
    input  logic                          wr_v0,
    input  tlb_pkg::mat_t                 wr_mat0,
    input  tlb_pkg::ppn_t                 wr_ppn0,
    input  logic                          wr_v1,
    input  tlb_pkg::mat_t                 wr_mat1,
    input  tlb_pkg::ppn_t                 wr_ppn1,
    input  logic                          sweep_en,
    input  tlb_pkg::maint_op_t            sweep_op,
    input  tlb_pkg::tlb_idx_t             sweep_index,
    input  tlb_pkg::asid_t                key_asid,
    input  tlb_pkg::vppn_t                key_vppn,
    input  tlb_pkg::asid_t                look_asid,
    input  tlb_pkg::va_t                  look_va,
    input  tlb_pkg::tlb_idx_t             rd_index,
    output logic                          sweep_match,
    output logic [tlb_pkg::TLB_NUM-1:0]   look_hits,
    output tlb_pkg::ps_t                  rd_ps,
    output logic                          rd_v0,
    output tlb_pkg::mat_t                 rd_mat0,
    output tlb_pkg::ppn_t                 rd_ppn0,
    output logic                          rd_v1,
    output tlb_pkg::mat_t                 rd_mat1,
    output tlb_pkg::ppn_t                 rd_ppn1
);
    import tlb_pkg::*;

    logic [TLB_NUM-1:0] ent_e;
    logic [TLB_NUM-1:0] ent_g;
    asid_t              ent_asid [TLB_NUM];
    ps_t                ent_ps   [TLB_NUM];
    vppn_t              ent_vppn [TLB_NUM];
    logic [TLB_NUM-1:0] ent_v0;
    logic [TLB_NUM-1:0] ent_v1;
    mat_t               ent_mat0 [TLB_NUM];
    mat_t               ent_mat1 [TLB_NUM];
    ppn_t               ent_ppn0 [TLB_NUM];
    ppn_t               ent_ppn1 [TLB_NUM];

    logic asid_eq;
    logic vppn_eq;
    logic is_inv;

    // Compare of the entry under the sweep pointer
    assign asid_eq = (ent_asid[sweep_index] == key_asid);
    assign vppn_eq = (ent_vppn[sweep_index] == key_vppn);
    assign is_inv  = (sweep_op == MOP_INV_ALL) || (sweep_op == MOP_INV_ASID) ||
                     (sweep_op == MOP_INV_VA);

    always_comb begin
        case (sweep_op)
            MOP_SEARCH:   sweep_match = ent_e[sweep_index] &&
                                        (ent_g[sweep_index] || asid_eq) && vppn_eq;
            MOP_INV_ALL:  sweep_match = 1'b1;
            MOP_INV_ASID: sweep_match = ent_e[sweep_index] && !ent_g[sweep_index] && asid_eq;
            MOP_INV_VA:   sweep_match = ent_e[sweep_index] && !ent_g[sweep_index] &&
                                        asid_eq && vppn_eq;
            default:      sweep_match = 1'b0;
        endcase
    end

    // Valid bits, set by a write and cleared by an invalidate sweep
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ent_e <= '0;
        end else if (wr_en) begin
            ent_e[wr_index] <= 1'b1;
        end else if (sweep_en && is_inv && sweep_match) begin
            ent_e[sweep_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ent_g[wr_index]    <= wr_g;
            ent_asid[wr_index] <= wr_asid;
            ent_ps[wr_index]   <= wr_ps;
            ent_vppn[wr_index] <= wr_vppn;
            ent_v0[wr_index]   <= wr_v0;
            ent_mat0[wr_index] <= wr_mat0;
            ent_ppn0[wr_index] <= wr_ppn0;
            ent_v1[wr_index]   <= wr_v1;
            ent_mat1[wr_index] <= wr_mat1;
            ent_ppn1[wr_index] <= wr_ppn1;
        end
    end

    // Parallel match for the lookup stage
    for (genvar i = 0; i < TLB_NUM; i++) begin : g_hit
        assign look_hits[i] = entry_hits_va(ent_e[i], ent_g[i], ent_asid[i], ent_ps[i],
                                            ent_vppn[i], look_asid, look_va);
    end

    assign rd_ps   = ent_ps[rd_index];
    assign rd_v0   = ent_v0[rd_index];
    assign rd_mat0 = ent_mat0[rd_index];
    assign rd_ppn0 = ent_ppn0[rd_index];
    assign rd_v1   = ent_v1[rd_index];
    assign rd_mat1 = ent_mat1[rd_index];
    assign rd_ppn1 = ent_ppn1[rd_index];

endmodule

// ==== rtl/tlb_lookup.sv ====
`timescale 1ns/1ns

module tlb_lookup (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          flush,
    input  logic                          va_valid,
    input  tlb_pkg::va_t                  va,
    input  logic                          pg,
    input  tlb_pkg::mat_t                 da_mat,
    input  tlb_pkg::dmw_t                 dmw0,
    input  tlb_pkg::dmw_t                 dmw1,
    input  logic [tlb_pkg::TLB_NUM-1:0]   look_hits,
    input  tlb_pkg::ps_t                  rd_ps,
    input  logic                          rd_v0,
    input  tlb_pkg::mat_t                 rd_mat0,
    input  tlb_pkg::ppn_t                 rd_ppn0,
    input  logic                          rd_v1,
    input  tlb_pkg::mat_t                 rd_mat1,
    input  tlb_pkg::ppn_t                 rd_ppn1,
    output tlb_pkg::va_t                  look_va,
    output tlb_pkg::tlb_idx_t             rd_index,
    output logic                          pa_valid,
    output tlb_pkg::pa_t                  pa,
    output logic                          pa_cached,
    output logic                          pa_miss
);
    import tlb_pkg::*;

    logic     s1_valid;
    va_t      s1_va;
    logic     s1_hit;
    tlb_idx_t hit_index;

    logic     page_4k;
    logic     odd;
    logic     half_v;
    mat_t     half_mat;
    ppn_t     half_ppn;
    pa_t      tlb_pa;
    logic     win0_hit;
    logic     win1_hit;
    pa_t      nxt_pa;
    logic     nxt_cached;
    logic     nxt_miss;

    // Entries match against the VA in the request cycle
    assign look_va = va;

    // Lowest hitting index wins
    always_comb begin
        hit_index = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (look_hits[i])
                hit_index = tlb_idx_t'(i);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            s1_valid <= 1'b0;
        else if (flush)
            s1_valid <= 1'b0;
        else
            s1_valid <= va_valid;
    end

    always_ff @(posedge clk) begin
        s1_va    <= va;
        s1_hit   <= |look_hits;
        rd_index <= hit_index;
    end

    // Page half select and PA build from the stored entry
    assign page_4k  = (rd_ps == ps_t'(PS_4K));
    assign odd      = page_4k ? s1_va[PS_4K] : s1_va[PS_2M];
    assign half_v   = odd ? rd_v1 : rd_v0;
    assign half_mat = odd ? rd_mat1 : rd_mat0;
    assign half_ppn = odd ? rd_ppn1 : rd_ppn0;
    assign tlb_pa   = page_4k ? {half_ppn, s1_va[PS_4K-1:0]} :
                                {half_ppn[PPN_W-1:PS_2M-12], s1_va[PS_2M-1:0]};

    assign win0_hit = (s1_va[31:29] == dmw0[31:29]);
    assign win1_hit = (s1_va[31:29] == dmw1[31:29]);

    always_comb begin
        nxt_miss = 1'b0;
        if (!pg) begin
            nxt_pa     = s1_va;
            nxt_cached = (da_mat == MAT_CC);
        end else if (win0_hit) begin
            nxt_pa     = {dmw0[27:25], s1_va[28:0]};
            nxt_cached = (dmw0[5:4] == MAT_CC);
        end else if (win1_hit) begin
            nxt_pa     = {dmw1[27:25], s1_va[28:0]};
            nxt_cached = (dmw1[5:4] == MAT_CC);
        end else if (s1_hit && half_v) begin
            nxt_pa     = tlb_pa;
            nxt_cached = (half_mat == MAT_CC);
        end else begin
            nxt_pa     = '0;
            nxt_cached = 1'b0;
            nxt_miss   = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            pa_valid <= 1'b0;
        else if (flush)
            pa_valid <= 1'b0;
        else
            pa_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        pa        <= nxt_pa;
        pa_cached <= nxt_cached;
        pa_miss   <= nxt_miss;
    end

endmodule

// ==== rtl/tlb_sweep_counter.sv ====
`timescale 1ns/1ns

module tlb_sweep_counter (
    input  logic              clk,
    input  logic              rstn,
    input  logic              sweep_start,
    input  logic              sweep_step,
    output tlb_pkg::tlb_idx_t sweep_index,
    output logic              sweep_last
);
    import tlb_pkg::*;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            sweep_index <= '0;
        else if (sweep_start)
            sweep_index <= '0;
        else if (sweep_step)
            sweep_index <= sweep_index + 1'b1;
    end

    // Final entry of the table
    assign sweep_last = (sweep_index == tlb_idx_t'(TLB_NUM - 1));

endmodule

// ==== rtl/tlb_maint_fsm.sv ====
`timescale 1ns/1ns

module tlb_maint_fsm (
    input  logic               clk,
    input  logic               rstn,
    input  logic               maint_req,
    input  tlb_pkg::maint_op_t maint_op,
    input  tlb_pkg::tlb_idx_t  sweep_index,
    input  logic               sweep_last,
    input  logic               sweep_match,
    output logic               maint_ack,
    output logic               wr_en,
    output logic               sweep_en,
    output logic               sweep_start,
    output logic               sweep_step,
    output logic               srch_hit,
    output tlb_pkg::tlb_idx_t  srch_index
);
    import tlb_pkg::*;

    maint_state_t state;
    logic         is_search;
    logic         sweep_done;

    assign is_search  = (maint_op == MOP_SEARCH);
    // Search stops at the first match, invalidates run to the end
    assign sweep_done = sweep_last || (is_search && sweep_match);

    assign maint_ack   = (state == MS_ACK);
    assign wr_en       = (state == MS_WRITE);
    assign sweep_en    = (state == MS_SWEEP);
    assign sweep_step  = (state == MS_SWEEP);
    assign sweep_start = (state == MS_IDLE) && maint_req && (maint_op != MOP_WRITE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= MS_IDLE;
            srch_hit <= 1'b0;
        end else begin
            case (state)
                MS_IDLE: begin
                    if (maint_req)
                        state <= (maint_op == MOP_WRITE) ? MS_WRITE : MS_SWEEP;
                end
                MS_WRITE: begin
                    state <= MS_ACK;
                end
                MS_SWEEP: begin
                    if (sweep_done) begin
                        state <= MS_ACK;
                        if (is_search)
                            srch_hit <= sweep_match;
                    end
                end
                MS_ACK: begin
                    // Four-phase return, wait for the request to drop
                    if (!maint_req)
                        state <= MS_IDLE;
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == MS_SWEEP) && is_search && sweep_done)
            srch_index <= sweep_index;
    end

endmodule

// ==== rtl/tlb_top.sv ====
`timescale 1ns/1ns

module tlb_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush,
    input  logic               va_valid,
    input  tlb_pkg::va_t       va,
    input  tlb_pkg::asid_t     asid,
    input  logic               pg,
    input  tlb_pkg::mat_t      da_mat,
    input  tlb_pkg::dmw_t      dmw0,
    input  tlb_pkg::dmw_t      dmw1,
    output logic               pa_valid,
    output tlb_pkg::pa_t       pa,
    output logic               pa_cached,
    output logic               pa_miss,
    input  logic               maint_req,
    input  tlb_pkg::maint_op_t maint_op,
    output logic               maint_ack,
    output logic               srch_hit,
    output tlb_pkg::tlb_idx_t  srch_index,
    input  tlb_pkg::tlb_idx_t  wr_index,
    input  tlb_pkg::asid_t     wr_asid,
    input  logic               wr_g,
    input  tlb_pkg::ps_t       wr_ps,
    input  tlb_pkg::vppn_t     wr_vppn,
    input  logic               wr_v0,
    input  tlb_pkg::mat_t      wr_mat0,
    input  tlb_pkg::ppn_t      wr_ppn0,
    input  logic               wr_v1,
    input  tlb_pkg::mat_t      wr_mat1,
    input  tlb_pkg::ppn_t      wr_ppn1,
    input  tlb_pkg::asid_t     key_asid,
    input  tlb_pkg::vppn_t     key_vppn
);
    import tlb_pkg::*;

    // Lookup side
    va_t                look_va;
    logic [TLB_NUM-1:0] look_hits;
    tlb_idx_t           rd_index;
    ps_t                rd_ps;
    logic               rd_v0;
    mat_t               rd_mat0;
    ppn_t               rd_ppn0;
    logic               rd_v1;
    mat_t               rd_mat1;
    ppn_t               rd_ppn1;

    // Maintenance side
    logic               wr_en;
    logic               sweep_en;
    logic               sweep_start;
    logic               sweep_step;
    tlb_idx_t           sweep_index;
    logic               sweep_last;
    logic               sweep_match;

    tlb_entry_array u_array (
        .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_index(wr_index),
        .wr_asid(wr_asid), .wr_g(wr_g), .wr_ps(wr_ps), .wr_vppn(wr_vppn),
        .wr_v0(wr_v0), .wr_mat0(wr_mat0), .wr_ppn0(wr_ppn0),
        .wr_v1(wr_v1), .wr_mat1(wr_mat1), .wr_ppn1(wr_ppn1),
        .sweep_en(sweep_en), .sweep_op(maint_op), .sweep_index(sweep_index),
        .key_asid(key_asid), .key_vppn(key_vppn),
        .look_asid(asid), .look_va(look_va), .rd_index(rd_index),
        .sweep_match(sweep_match), .look_hits(look_hits), .rd_ps(rd_ps),
        .rd_v0(rd_v0), .rd_mat0(rd_mat0), .rd_ppn0(rd_ppn0),
        .rd_v1(rd_v1), .rd_mat1(rd_mat1), .rd_ppn1(rd_ppn1)
    );

    tlb_lookup u_lookup (
        .clk(clk), .rstn(rstn), .flush(flush), .va_valid(va_valid), .va(va),
        .pg(pg), .da_mat(da_mat), .dmw0(dmw0), .dmw1(dmw1),
        .look_hits(look_hits), .rd_ps(rd_ps),
        .rd_v0(rd_v0), .rd_mat0(rd_mat0), .rd_ppn0(rd_ppn0),
        .rd_v1(rd_v1), .rd_mat1(rd_mat1), .rd_ppn1(rd_ppn1),
        .look_va(look_va), .rd_index(rd_index),
        .pa_valid(pa_valid), .pa(pa), .pa_cached(pa_cached), .pa_miss(pa_miss)
    );

    tlb_sweep_counter u_counter (
        .clk(clk), .rstn(rstn), .sweep_start(sweep_start), .sweep_step(sweep_step),
        .sweep_index(sweep_index), .sweep_last(sweep_last)
    );

    tlb_maint_fsm u_fsm (
        .clk(clk), .rstn(rstn), .maint_req(maint_req), .maint_op(maint_op),
        .sweep_index(sweep_index), .sweep_last(sweep_last), .sweep_match(sweep_match),
        .maint_ack(maint_ack), .wr_en(wr_en), .sweep_en(sweep_en),
        .sweep_start(sweep_start), .sweep_step(sweep_step),
        .srch_hit(srch_hit), .srch_index(srch_index)
    );

endmodule

// ==== tests/tlb_sva.sv ====
`timescale 1ns/1ns

module tlb_sva (
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic va_valid,
    input logic pa_valid,
    input logic maint_req,
    input logic maint_ack
);

    // Four-phase return, ack stays up until the request drops
    ack_held: assert property (@(posedge clk) disable iff (!rstn)
        $past(maint_ack && maint_req) |-> maint_ack)
        else $error("maint_ack fell while maint_req was still high");

    ack_rise: assert property (@(posedge clk) disable iff (!rstn)
        $rose(maint_ack) |-> maint_req)
        else $error("maint_ack rose without maint_req");

    // Two-stage lookup pipeline
    pa_timing: assert property (@(posedge clk) disable iff (!rstn)
        $past(va_valid, 2) && !$past(flush, 2) && !$past(flush, 1) |-> pa_valid)
        else $error("pa_valid missing two cycles after va_valid");

    reset_clear: assert property (@(posedge clk)
        $rose(rstn) |-> !pa_valid)
        else $error("pa_valid high in the first cycle after reset");

endmodule

bind tlb_top tlb_sva u_sva (
    .clk(clk),
    .rstn(rstn),
    .flush(flush),
    .va_valid(va_valid),
    .pa_valid(pa_valid),
    .maint_req(maint_req),
    .maint_ack(maint_ack)
);

// ==== tests/tb_tlb.sv ====
`timescale 1ns/1ns

module tb_tlb;
    import tlb_pkg::*;

    localparam int WAIT_LIMIT = 64;

    logic      clk;
    logic      rstn;
    logic      flush;
    logic      va_valid;
    va_t       va;
    asid_t     asid;
    logic      pg;
    mat_t      da_mat;
    dmw_t      dmw0;
    dmw_t      dmw1;
    logic      pa_valid;
    pa_t       pa;
    logic      pa_cached;
    logic      pa_miss;
    logic      maint_req;
    maint_op_t maint_op;
    logic      maint_ack;
    logic      srch_hit;
    tlb_idx_t  srch_index;
    tlb_idx_t  wr_index;
    asid_t     wr_asid;
    logic      wr_g;
    ps_t       wr_ps;
    vppn_t     wr_vppn;
    logic      wr_v0;
    mat_t      wr_mat0;
    ppn_t      wr_ppn0;
    logic      wr_v1;
    mat_t      wr_mat1;
    ppn_t      wr_ppn1;
    asid_t     key_asid;
    vppn_t     key_vppn;

    // Reference copy of the table
    // m_w marks entries ever written
    logic  m_w    [TLB_NUM];
    logic  m_e    [TLB_NUM];
    logic  m_g    [TLB_NUM];
    logic  m_big  [TLB_NUM];
    asid_t m_asid [TLB_NUM];
    vppn_t m_vppn [TLB_NUM];
    logic  m_v    [TLB_NUM][2];
    mat_t  m_mat  [TLB_NUM][2];
    ppn_t  m_ppn  [TLB_NUM][2];

    integer seed;
    int     errors;
    int     tests;
    int     failed;
    string  cur_test;

    tlb_top UUT (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s ok", cur_test);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", cur_test, errors - err0);
        end
    endtask

    // Translation as the page rules define it
    function automatic void model_translate(input va_t v, output pa_t p, output logic c,
                                            output logic m);
        int   hit;
        logic h;
        hit = -1;
        p = '0;
        c = 1'b0;
        m = 1'b0;
        if (!pg) begin
            p = v;
            c = (da_mat == MAT_CC);
            return;
        end
        if (v[31:29] == dmw0[31:29]) begin
            p = {dmw0[27:25], v[28:0]};
            c = (dmw0[5:4] == MAT_CC);
            return;
        end
        if (v[31:29] == dmw1[31:29]) begin
            p = {dmw1[27:25], v[28:0]};
            c = (dmw1[5:4] == MAT_CC);
            return;
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            if (hit < 0 && m_e[i] && (m_g[i] || m_asid[i] == asid)) begin
                if (m_big[i] ? (m_vppn[i][18:9] == v[31:22]) : (m_vppn[i] == v[31:13]))
                    hit = i;
            end
        end
        if (hit < 0) begin
            m = 1'b1;
            return;
        end
        h = m_big[hit] ? v[21] : v[12];
        if (!m_v[hit][h]) begin
            m = 1'b1;
            return;
        end
        p = m_big[hit] ? {m_ppn[hit][h][19:9], v[20:0]} : {m_ppn[hit][h], v[11:0]};
        c = (m_mat[hit][h] == MAT_CC);
    endfunction

    task automatic check_result(input va_t v);
        pa_t  exp_pa;
        logic exp_cached;
        logic exp_miss;
        model_translate(v, exp_pa, exp_cached, exp_miss);
        check_bit("pa_valid", 1'b1, pa_valid);
        check_value("pa", exp_pa, pa);
        check_bit("pa_cached", exp_cached, pa_cached);
        check_bit("pa_miss", exp_miss, pa_miss);
    endtask

    task automatic lookup_check(input va_t v, input asid_t a);
        @(posedge clk);
        va_valid <= 1'b1;
        va       <= v;
        asid     <= a;
        @(posedge clk);
        va_valid <= 1'b0;
        @(negedge clk);
        check_bit("pa_valid early", 1'b0, pa_valid);
        @(negedge clk);
        check_result(v);
        @(negedge clk);
        check_bit("pa_valid held", 1'b0, pa_valid);
    endtask

    // Two lookups in flight at once
    task automatic lookup_pair(input va_t v0, input va_t v1, input asid_t a);
        @(posedge clk);
        va_valid <= 1'b1;
        va       <= v0;
        asid     <= a;
        @(posedge clk);
        va       <= v1;
        @(posedge clk);
        va_valid <= 1'b0;
        @(negedge clk);
        check_result(v0);
        @(negedge clk);
        check_result(v1);
    endtask

    // Flush in stage 1, then flush in stage 2
    task automatic flush_check(input va_t v);
        @(posedge clk);
        va_valid <= 1'b1;
        va       <= v;
        flush    <= 1'b1;
        @(posedge clk);
        va_valid <= 1'b0;
        flush    <= 1'b0;
        repeat (2) @(negedge clk);
        check_bit("pa_valid after stage 1 flush", 1'b0, pa_valid);
        @(posedge clk);
        va_valid <= 1'b1;
        va       <= v;
        @(posedge clk);
        va_valid <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
        @(negedge clk);
        check_bit("pa_valid after stage 2 flush", 1'b0, pa_valid);
        @(negedge clk);
        check_bit("pa_valid after flush", 1'b0, pa_valid);
    endtask

    task automatic maint_handshake(input maint_op_t op, input int exp_cycles,
                                   output logic hit, output tlb_idx_t idx);
        int   cycles;
        logic seen;
        @(posedge clk);
        maint_op  <= op;
        maint_req <= 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = maint_ack;
        end
        hit = srch_hit;
        idx = srch_index;
        if (!seen) begin
            $display("Timeout in %s: maint_ack never rose", cur_test);
            errors++;
        end else if (exp_cycles > 0) begin
            check_value("ack latency", exp_cycles, cycles);
        end
        @(posedge clk);
        maint_req <= 1'b0;
        cycles = 0;
        while (seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = maint_ack;
        end
        if (seen) begin
            $display("Timeout in %s: maint_ack stayed high after the request dropped",
                     cur_test);
            errors++;
        end
    endtask

    task automatic maint_write(input tlb_idx_t idx, input asid_t a, input logic g,
                               input logic big, input vppn_t vp,
                               input logic v0, input mat_t mat0, input ppn_t ppn0,
                               input logic v1, input mat_t mat1, input ppn_t ppn1);
        logic     hit;
        tlb_idx_t found;
        @(posedge clk);
        wr_index <= idx;
        wr_asid  <= a;
        wr_g     <= g;
        wr_ps    <= big ? ps_t'(PS_2M) : ps_t'(PS_4K);
        wr_vppn  <= vp;
        wr_v0    <= v0;
        wr_mat0  <= mat0;
        wr_ppn0  <= ppn0;
        wr_v1    <= v1;
        wr_mat1  <= mat1;
        wr_ppn1  <= ppn1;
        maint_handshake(MOP_WRITE, 2, hit, found);
        m_w[idx]      = 1'b1;
        m_e[idx]      = 1'b1;
        m_g[idx]      = g;
        m_big[idx]    = big;
        m_asid[idx]   = a;
        m_vppn[idx]   = vp;
        m_v[idx][0]   = v0;
        m_mat[idx][0] = mat0;
        m_ppn[idx][0] = ppn0;
        m_v[idx][1]   = v1;
        m_mat[idx][1] = mat1;
        m_ppn[idx][1] = ppn1;
    endtask

    task automatic maint_search(input asid_t a, input vppn_t vp);
        logic     hit;
        tlb_idx_t found;
        logic     exp_hit;
        int       exp_idx;
        exp_hit = 1'b0;
        exp_idx = 0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (!exp_hit && m_e[i] && (m_g[i] || m_asid[i] == a) && m_vppn[i] == vp) begin
                exp_hit = 1'b1;
                exp_idx = i;
            end
        end
        @(posedge clk);
        key_asid <= a;
        key_vppn <= vp;
        maint_handshake(MOP_SEARCH, 0, hit, found);
        check_bit("srch_hit", exp_hit, hit);
        if (exp_hit)
            check_value("srch_index", exp_idx, 32'(found));
    endtask

    task automatic maint_inv(input maint_op_t op, input asid_t a, input vppn_t vp);
        logic     hit;
        tlb_idx_t found;
        @(posedge clk);
        key_asid <= a;
        key_vppn <= vp;
        maint_handshake(op, TLB_NUM + 1, hit, found);
        for (int i = 0; i < TLB_NUM; i++) begin
            if (op == MOP_INV_ALL)
                m_e[i] = 1'b0;
            else if (m_e[i] && !m_g[i] && m_asid[i] == a &&
                     (op == MOP_INV_ASID || m_vppn[i] == vp))
                m_e[i] = 1'b0;
        end
    endtask

    // Even-half lookup of every entry ever written
    task automatic survey_table();
        va_t v;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (m_w[i]) begin
                if (m_big[i])
                    v = {m_vppn[i][18:9], 1'b0, 21'($random(seed))};
                else
                    v = {m_vppn[i], 1'b0, 12'($random(seed))};
                lookup_check(v, m_asid[i]);
            end
        end
    endtask

    task automatic apply_reset();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        cur_test = "reset";
        @(negedge clk);
        check_bit("pa_valid", 1'b0, pa_valid);
        check_bit("maint_ack", 1'b0, maint_ack);
        check_bit("srch_hit", 1'b0, srch_hit);
        @(posedge clk);
        pg <= 1'b1;
        lookup_check(32'h0000_5000, 10'h000);
        lookup_check(32'h1234_0000, 10'h3FF);
        report_test(err0);
    endtask

    task automatic test_direct();
        int err0;
        err0 = errors;
        cur_test = "direct";
        @(posedge clk);
        pg     <= 1'b0;
        da_mat <= MAT_CC;
        lookup_check(va_t'($random(seed)), 10'h000);
        @(posedge clk);
        da_mat <= 2'd0;
        lookup_check(va_t'($random(seed)), 10'h000);
        lookup_pair(va_t'($random(seed)), va_t'($random(seed)), 10'h000);
        report_test(err0);
    endtask

    task automatic test_flush();
        int err0;
        err0 = errors;
        cur_test = "flush";
        flush_check(va_t'($random(seed)));
        lookup_check(va_t'($random(seed)), 10'h000);
        report_test(err0);
    endtask

    task automatic test_windows();
        int err0;
        err0 = errors;
        cur_test = "windows";
        @(posedge clk);
        pg   <= 1'b1;
        dmw0 <= {3'd5, 1'b0, 3'd1, 19'd0, 2'd1, 4'd0};
        dmw1 <= {3'd4, 1'b0, 3'd2, 19'd0, 2'd0, 4'd0};
        lookup_check({3'd5, 29'($random(seed))}, 10'h000);
        lookup_check({3'd4, 29'($random(seed))}, 10'h000);
        // Both windows on one segment
        @(posedge clk);
        dmw1 <= {3'd5, 1'b0, 3'd6, 19'd0, 2'd0, 4'd0};
        lookup_check({3'd5, 29'($random(seed))}, 10'h000);
        @(posedge clk);
        dmw0 <= 32'hE000_0000;
        dmw1 <= 32'hC000_0000;
        report_test(err0);
    endtask

    task automatic test_4k();
        int err0;
        err0 = errors;
        cur_test = "page_4k";
        maint_write(4'd3, 10'h021, 1'b0, 1'b0, 19'h01234,
                    1'b1, 2'd1, 20'hABCDE, 1'b1, 2'd0, 20'h13579);
        maint_write(4'd5, 10'h3FF, 1'b1, 1'b0, 19'h02000,
                    1'b1, 2'd1, 20'h22222, 1'b0, 2'd1, 20'h33333);
        lookup_check({19'h01234, 1'b0, 12'($random(seed))}, 10'h021);
        lookup_check({19'h01234, 1'b1, 12'($random(seed))}, 10'h021);
        lookup_check({19'h01234, 1'b0, 12'($random(seed))}, 10'h055);
        lookup_check({19'h02000, 1'b0, 12'($random(seed))}, 10'h055);
        lookup_check({19'h02000, 1'b1, 12'($random(seed))}, 10'h021);
        report_test(err0);
    endtask

    task automatic test_2m();
        int err0;
        err0 = errors;
        cur_test = "page_2m";
        maint_write(4'd8, 10'h021, 1'b0, 1'b1, {10'h1A3, 9'h000},
                    1'b1, 2'd1, 20'h0C800, 1'b1, 2'd2, 20'h0F400);
        lookup_check({10'h1A3, 1'b0, 21'($random(seed))}, 10'h021);
        lookup_check({10'h1A3, 1'b1, 21'($random(seed))}, 10'h021);
        report_test(err0);
    endtask

    task automatic test_search();
        int err0;
        err0 = errors;
        cur_test = "search";
        maint_write(4'd10, 10'h021, 1'b0, 1'b0, 19'h01234,
                    1'b1, 2'd1, 20'h44444, 1'b1, 2'd1, 20'h55555);
        maint_search(10'h021, 19'h01234);
        maint_search(10'h021, 19'h7FFFF);
        maint_search(10'h100, 19'h02000);
        maint_search(10'h100, 19'h01234);
        report_test(err0);
    endtask

    task automatic test_invalidate();
        int err0;
        err0 = errors;
        cur_test = "invalidate";
        maint_write(4'd12, 10'h055, 1'b0, 1'b0, 19'h03000,
                    1'b1, 2'd1, 20'h66666, 1'b1, 2'd1, 20'h77777);
        maint_inv(MOP_INV_VA, 10'h021, 19'h01234);
        survey_table();
        maint_inv(MOP_INV_ASID, 10'h021, 19'h00000);
        survey_table();
        maint_inv(MOP_INV_ALL, 10'h000, 19'h00000);
        survey_table();
        report_test(err0);
    endtask

    initial begin
        seed      = 61;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        clk       = 1'b0;
        rstn      = 1'b0;
        flush     = 1'b0;
        va_valid  = 1'b0;
        va        = '0;
        asid      = '0;
        pg        = 1'b0;
        da_mat    = '0;
        dmw0      = 32'hE000_0000;
        dmw1      = 32'hC000_0000;
        maint_req = 1'b0;
        maint_op  = MOP_WRITE;
        wr_index  = '0;
        wr_asid   = '0;
        wr_g      = 1'b0;
        wr_ps     = '0;
        wr_vppn   = '0;
        wr_v0     = 1'b0;
        wr_mat0   = '0;
        wr_ppn0   = '0;
        wr_v1     = 1'b0;
        wr_mat1   = '0;
        wr_ppn1   = '0;
        key_asid  = '0;
        key_vppn  = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            m_w[i] = 1'b0;
            m_e[i] = 1'b0;
        end
        apply_reset();
        test_reset();
        test_direct();
        test_flush();
        test_windows();
        test_4k();
        test_2m();
        test_search();
        test_invalidate();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/tlb_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_lookup.sv
rtl/tlb_sweep_counter.sv
rtl/tlb_maint_fsm.sv
rtl/tlb_top.sv
tests/tlb_sva.sv
tests/tb_tlb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_tlb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
